/* vlog.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/pipe_reg.sv
rtl/regfile.sv
rtl/ifu.sv
rtl/idu.sv
rtl/exu.sv
rtl/cpu_top.sv
bench/tb_cpu.sv

/* Makefile */
# Verilator build and run of the RV32I pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: sim clean

sim:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_cpu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu;

	localparam int prog_depth = 256;

	logic              clock = 1'b0;
	logic              arst_n_i = 1'b0;
	logic              inst_req_o;
	cpu_pkg::xlen_t    inst_addr_o;
	logic              inst_valid_i = 1'b0;
	cpu_pkg::xlen_t    inst_i = '0;
	logic              commit_valid_o;
	cpu_pkg::xlen_t    commit_pc_o;
	logic              commit_wen_o;
	cpu_pkg::reg_idx_t commit_rd_o;
	cpu_pkg::xlen_t    commit_data_o;

	// program image and the edge at which each word was sampled
	cpu_pkg::xlen_t prog [prog_depth];
	int             sample_cyc [prog_depth];
	int             prog_len = 0;

	// reference register file and commits still to come
	cpu_pkg::xlen_t model_regs [`CPU_REG_NUM];
	cpu_pkg::wb_t   exp_q [$];

	int             cycle = 0;
	int             errors = 0;
	int             checks = 0;
	logic [15:0]    lfsr = 16'd62552;
	logic           rand_delay = 1'b1;

	// responder state
	logic           waiting = 1'b0;
	int             wait_cnt = 0;
	cpu_pkg::xlen_t req_addr = '0;
	cpu_pkg::xlen_t next_req_addr = `CPU_RESET_PC;
	cpu_pkg::xlen_t first_req_addr = '0;
	int             req_count = 0;

	cpu_top dut_i (
		.clock          (clock),
		.arst_n_i       (arst_n_i),
		.inst_req_o     (inst_req_o),
		.inst_addr_o    (inst_addr_o),
		.inst_valid_i   (inst_valid_i),
		.inst_i         (inst_i),
		.commit_valid_o (commit_valid_o),
		.commit_pc_o    (commit_pc_o),
		.commit_wen_o   (commit_wen_o),
		.commit_rd_o    (commit_rd_o),
		.commit_data_o  (commit_data_o)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// rv32i integer semantics, alt means sub or sra
	function automatic cpu_pkg::xlen_t alu_model(
		input logic [2:0]     f3,
		input logic           alt,
		input cpu_pkg::xlen_t a,
		input cpu_pkg::xlen_t b
	);
		cpu_pkg::xlen_t     r;
		logic signed [31:0] sa;
		sa = $signed(a) >>> b[4:0];
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: r = alt ? cpu_pkg::xlen_t'(sa) : a >> b[4:0];
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	task automatic emit_inst(
		input cpu_pkg::xlen_t    inst,
		input logic              wen,
		input cpu_pkg::reg_idx_t rd,
		input cpu_pkg::xlen_t    value
	);
		cpu_pkg::wb_t e;
		e.pc     = `CPU_RESET_PC + cpu_pkg::xlen_t'(prog_len * 4);
		e.rd     = rd;
		e.wen    = wen && rd != '0;
		e.result = value;
		if (e.wen) begin
			model_regs[rd] = value;
		end
		prog[prog_len] = inst;
		exp_q.push_back(e);
		prog_len++;
	endtask

	task automatic issue_imm(
		input logic [2:0]        f3,
		input cpu_pkg::reg_idx_t rd,
		input cpu_pkg::reg_idx_t rs1,
		input logic [11:0]       imm
	);
		cpu_pkg::xlen_t b;
		b = {{20{imm[11]}}, imm};
		emit_inst({imm, rs1, f3, rd, 7'b0010011}, 1'b1, rd,
			alu_model(f3, f3 == 3'd5 && imm[10], model_regs[rs1], b));
	endtask

	task automatic issue_reg(
		input logic [2:0]        f3,
		input logic              alt,
		input cpu_pkg::reg_idx_t rd,
		input cpu_pkg::reg_idx_t rs1,
		input cpu_pkg::reg_idx_t rs2
	);
		emit_inst({(alt ? 7'h20 : 7'h00), rs2, rs1, f3, rd, 7'b0110011}, 1'b1, rd,
			alu_model(f3, alt, model_regs[rs1], model_regs[rs2]));
	endtask

	task automatic load_upper(input cpu_pkg::reg_idx_t rd, input logic [19:0] imm);
		emit_inst({imm, rd, 7'b0110111}, 1'b1, rd, {imm, 12'h000});
	endtask

	task automatic add_upper_pc(input cpu_pkg::reg_idx_t rd, input logic [19:0] imm);
		cpu_pkg::xlen_t pc;
		pc = `CPU_RESET_PC + cpu_pkg::xlen_t'(prog_len * 4);
		emit_inst({imm, rd, 7'b0010111}, 1'b1, rd, pc + {imm, 12'h000});
	endtask

	// encodings outside the subset retire without a write
	task automatic raw_word(input cpu_pkg::xlen_t inst);
		emit_inst(inst, 1'b0, inst[11:7], '0);
	endtask

	task automatic drain_pipeline();
		while (exp_q.size() != 0) begin
			@(posedge clock);
		end
	endtask

	// answers one request at a time after 0 to 3 idle cycles
	always @(posedge clock) begin
		int         idx;
		logic [1:0] d;
		inst_valid_i <= 1'b0;
		if (arst_n_i) begin
			if (inst_req_o) begin
				checks++;
				if (inst_addr_o !== next_req_addr) begin
					$display("[FAIL] inst_addr_o got %h expected %h", inst_addr_o, next_req_addr);
					errors++;
				end
				if (req_count == 0) begin
					first_req_addr = inst_addr_o;
				end
				req_count++;
				next_req_addr = next_req_addr + 4;
				req_addr = inst_addr_o;
				d = 2'd0;
				if (rand_delay) begin
					lfsr = lfsr_next(lfsr);
					d[0] = lfsr[0];
					lfsr = lfsr_next(lfsr);
					d[1] = lfsr[0];
				end
				wait_cnt = int'(d);
				waiting = 1'b1;
			end
			if (waiting) begin
				idx = (req_addr - `CPU_RESET_PC) >> 2;
				if (wait_cnt != 0) begin
					wait_cnt--;
				end else if (idx < prog_len) begin
					inst_valid_i <= 1'b1;
					inst_i <= prog[idx];
					sample_cyc[idx] = cycle + 1;
					waiting = 1'b0;
				end
			end
		end
	end

	// compare each commit with the oldest expected one
	always @(posedge clock) begin
		cpu_pkg::wb_t e;
		int           idx;
		if (arst_n_i && commit_valid_o) begin
			if (exp_q.size() == 0) begin
				$display("commit at pc %h arrived with no instruction outstanding", commit_pc_o);
				errors++;
			end else begin
				e = exp_q.pop_front();
				idx = (e.pc - `CPU_RESET_PC) >> 2;
				checks++;
				if (commit_pc_o !== e.pc) begin
					$display("[FAIL] commit_pc_o got %h expected %h", commit_pc_o, e.pc);
					errors++;
				end
				if (commit_wen_o !== e.wen) begin
					$display("[FAIL] commit_wen_o got %h expected %h", commit_wen_o, e.wen);
					errors++;
				end
				if (commit_rd_o !== e.rd) begin
					$display("[FAIL] commit_rd_o got %h expected %h", commit_rd_o, e.rd);
					errors++;
				end
				if (e.wen && commit_data_o !== e.result) begin
					$display("[FAIL] commit_data_o got %h expected %h", commit_data_o, e.result);
					errors++;
				end
				if (cycle - 1 - sample_cyc[idx] != 3) begin
					$display("commit of pc %h came %0d edges after its response instead of 3",
						e.pc, cycle - 1 - sample_cyc[idx]);
					errors++;
				end
			end
		end
	end

	// limit grows with the program, 8 cycles per instruction
	always @(posedge clock) begin
		if (cycle > prog_len * 8 + 200) begin
			$display("timeout after %0d cycles, %0d commits never arrived", cycle, exp_q.size());
			$display("Something failed");
			$finish;
		end
	end

	task automatic reset_sequence();
		for (int i = 0; i < 8; i++) begin
			@(negedge clock);
			checks++;
			if (commit_valid_o !== 1'b0) begin
				$display("[FAIL] commit_valid_o got %h expected 0 in reset", commit_valid_o);
				errors++;
			end
			checks++;
			if (inst_req_o !== 1'b0) begin
				$display("[FAIL] inst_req_o got %h expected 0 in reset", inst_req_o);
				errors++;
			end
		end
		@(posedge clock);
		arst_n_i <= 1'b1;
		while (req_count == 0) begin
			@(posedge clock);
		end
		if (first_req_addr !== `CPU_RESET_PC) begin
			$display("[FAIL] inst_addr_o got %h expected %h", first_req_addr, `CPU_RESET_PC);
			errors++;
		end
	endtask

	task automatic immediate_ops();
		rand_delay = 1'b1;
		issue_imm(3'd0, 5'd1, 5'd0, 12'h123);
		issue_imm(3'd0, 5'd2, 5'd1, 12'hffb);
		issue_imm(3'd2, 5'd3, 5'd2, 12'hfff);
		issue_imm(3'd3, 5'd4, 5'd2, 12'hfff);
		issue_imm(3'd4, 5'd5, 5'd1, 12'h0f0);
		issue_imm(3'd6, 5'd6, 5'd1, 12'h700);
		issue_imm(3'd7, 5'd7, 5'd1, 12'h0f0);
		issue_imm(3'd1, 5'd8, 5'd1, 12'h014);
		load_upper(5'd9, 20'hfedcb);
		issue_imm(3'd5, 5'd10, 5'd9, 12'h008);
		// srai, funct7 bit set in the immediate
		issue_imm(3'd5, 5'd11, 5'd9, 12'h408);
		add_upper_pc(5'd12, 20'h12345);
		drain_pipeline();
	endtask

	task automatic register_ops();
		rand_delay = 1'b1;
		// -16 and 5 so signed and unsigned compares disagree
		issue_imm(3'd0, 5'd13, 5'd0, 12'hff0);
		issue_imm(3'd0, 5'd14, 5'd0, 12'h005);
		issue_reg(3'd0, 1'b0, 5'd15, 5'd13, 5'd14);
		issue_reg(3'd0, 1'b1, 5'd16, 5'd14, 5'd13);
		issue_reg(3'd1, 1'b0, 5'd17, 5'd13, 5'd14);
		issue_reg(3'd2, 1'b0, 5'd18, 5'd13, 5'd14);
		issue_reg(3'd3, 1'b0, 5'd19, 5'd13, 5'd14);
		issue_reg(3'd4, 1'b0, 5'd20, 5'd13, 5'd14);
		issue_reg(3'd5, 1'b0, 5'd21, 5'd13, 5'd14);
		issue_reg(3'd5, 1'b1, 5'd22, 5'd13, 5'd14);
		issue_reg(3'd6, 1'b0, 5'd23, 5'd13, 5'd14);
		issue_reg(3'd7, 1'b0, 5'd24, 5'd13, 5'd14);
		issue_reg(3'd2, 1'b0, 5'd25, 5'd14, 5'd13);
		issue_reg(3'd3, 1'b0, 5'd26, 5'd14, 5'd13);
		drain_pipeline();
	endtask

	task automatic bypass_chain();
		rand_delay = 1'b0;
		issue_imm(3'd0, 5'd1, 5'd0, 12'h001);
		issue_reg(3'd0, 1'b0, 5'd2, 5'd1, 5'd1);
		// x2 from execute, x1 from writeback
		issue_reg(3'd0, 1'b0, 5'd3, 5'd2, 5'd1);
		issue_reg(3'd0, 1'b1, 5'd4, 5'd3, 5'd2);
		issue_reg(3'd1, 1'b0, 5'd5, 5'd3, 5'd4);
		issue_reg(3'd6, 1'b0, 5'd6, 5'd5, 5'd3);
		issue_imm(3'd0, 5'd6, 5'd6, 12'h7ff);
		issue_reg(3'd0, 1'b0, 5'd7, 5'd6, 5'd5);
		drain_pipeline();
	endtask

	task automatic suppressed_writes();
		rand_delay = 1'b1;
		issue_imm(3'd0, 5'd0, 5'd1, 12'h055);
		issue_reg(3'd0, 1'b0, 5'd8, 5'd0, 5'd0);
		// lw x5, beq and ecall are outside the subset
		raw_word(32'h0002_a283);
		issue_imm(3'd0, 5'd9, 5'd5, 12'h000);
		raw_word(32'h0000_0063);
		raw_word(32'h0000_0073);
		drain_pipeline();
	endtask

	task automatic commit_latency();
		rand_delay = 1'b0;
		issue_imm(3'd0, 5'd27, 5'd0, 12'h011);
		issue_imm(3'd0, 5'd28, 5'd27, 12'h022);
		load_upper(5'd29, 20'h0abcd);
		add_upper_pc(5'd30, 20'h00001);
		issue_reg(3'd0, 1'b0, 5'd31, 5'd29, 5'd28);
		drain_pipeline();
	endtask

	initial begin
		for (int i = 0; i < `CPU_REG_NUM; i++) begin
			model_regs[i] = '0;
		end
		reset_sequence();
		immediate_ops();
		register_ops();
		bypass_chain();
		suppressed_writes();
		commit_latency();
		repeat (4) @(posedge clock);
		$display("tb_cpu: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_top (
	input  logic              clock,
	input  logic              arst_n_i,

	// instruction port
	output logic              inst_req_o,
	output cpu_pkg::xlen_t    inst_addr_o,
	input  logic              inst_valid_i,
	input  cpu_pkg::xlen_t    inst_i,

	// commit port
	output logic              commit_valid_o,
	output cpu_pkg::xlen_t    commit_pc_o,
	output logic              commit_wen_o,
	output cpu_pkg::reg_idx_t commit_rd_o,
	output cpu_pkg::xlen_t    commit_data_o
);
	// fetch side
	logic              fetch_valid;
	cpu_pkg::fetch_t   fetch;
	logic              if_id_valid;
	cpu_pkg::fetch_t   if_id;

	// decode side
	cpu_pkg::reg_idx_t rs1;
	cpu_pkg::reg_idx_t rs2;
	cpu_pkg::xlen_t    rs1_data;
	cpu_pkg::xlen_t    rs2_data;
	logic              dec_valid;
	cpu_pkg::dec_t     dec;
	logic              id_ex_valid;
	cpu_pkg::dec_t     id_ex;

	// execute and writeback side
	cpu_pkg::wb_t      ex_out;
	logic              ex_wb_valid;
	cpu_pkg::wb_t      ex_wb;

	ifu u_ifu (
		.clock         (clock),
		.arst_n_i      (arst_n_i),
		.inst_req_o    (inst_req_o),
		.inst_addr_o   (inst_addr_o),
		.inst_valid_i  (inst_valid_i),
		.inst_i        (inst_i),
		.fetch_valid_o (fetch_valid),
		.fetch_o       (fetch)
	);

	pipe_reg #(
		.payload_t (cpu_pkg::fetch_t)
	) u_if_id (
		.clock    (clock),
		.arst_n_i (arst_n_i),
		.valid_i  (fetch_valid),
		.data_i   (fetch),
		.valid_o  (if_id_valid),
		.data_o   (if_id)
	);

	idu u_idu (
		.valid_i    (if_id_valid),
		.fetch_i    (if_id),
		.rs1_o      (rs1),
		.rs2_o      (rs2),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.ex_valid_i (id_ex_valid),
		.ex_fwd_i   (ex_out),
		.wb_valid_i (ex_wb_valid),
		.wb_fwd_i   (ex_wb),
		.valid_o    (dec_valid),
		.dec_o      (dec)
	);

	// write port is the writeback stage
	regfile u_regfile (
		.clock    (clock),
		.arst_n_i (arst_n_i),
		.raddr1_i (rs1),
		.raddr2_i (rs2),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data),
		.wen_i    (ex_wb_valid & ex_wb.wen),
		.waddr_i  (ex_wb.rd),
		.wdata_i  (ex_wb.result)
	);

	pipe_reg #(
		.payload_t (cpu_pkg::dec_t)
	) u_id_ex (
		.clock    (clock),
		.arst_n_i (arst_n_i),
		.valid_i  (dec_valid),
		.data_i   (dec),
		.valid_o  (id_ex_valid),
		.data_o   (id_ex)
	);

	exu u_exu (
		.dec_i (id_ex),
		.wb_o  (ex_out)
	);

	pipe_reg #(
		.payload_t (cpu_pkg::wb_t)
	) u_ex_wb (
		.clock    (clock),
		.arst_n_i (arst_n_i),
		.valid_i  (id_ex_valid),
		.data_i   (ex_out),
		.valid_o  (ex_wb_valid),
		.data_o   (ex_wb)
	);

	// commit shows the instruction in writeback
	assign commit_valid_o = ex_wb_valid;
	assign commit_pc_o    = ex_wb.pc;
	assign commit_wen_o   = ex_wb.wen;
	assign commit_rd_o    = ex_wb.rd;
	assign commit_data_o  = ex_wb.result;

endmodule

/* rtl/exu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module exu (
	input  cpu_pkg::dec_t dec_i,
	output cpu_pkg::wb_t  wb_o
);
	logic [4:0]     shamt;
	logic           lt_signed;
	logic           lt_unsigned;
	cpu_pkg::xlen_t result;

	// rv32 shifts use five bits of the amount
	assign shamt       = dec_i.op_b[4:0];
	assign lt_signed   = $signed(dec_i.op_a) < $signed(dec_i.op_b);
	assign lt_unsigned = dec_i.op_a < dec_i.op_b;

	always_comb begin
		case (dec_i.alu_op)
			cpu_pkg::alu_add:  result = dec_i.op_a + dec_i.op_b;
			cpu_pkg::alu_sub:  result = dec_i.op_a - dec_i.op_b;
			cpu_pkg::alu_sll:  result = dec_i.op_a << shamt;
			cpu_pkg::alu_slt:  result = {{(`CPU_XLEN-1){1'b0}}, lt_signed};
			cpu_pkg::alu_sltu: result = {{(`CPU_XLEN-1){1'b0}}, lt_unsigned};
			cpu_pkg::alu_xor:  result = dec_i.op_a ^ dec_i.op_b;
			cpu_pkg::alu_srl:  result = dec_i.op_a >> shamt;
			cpu_pkg::alu_sra:  result = cpu_pkg::xlen_t'($signed(dec_i.op_a) >>> shamt);
			cpu_pkg::alu_or:   result = dec_i.op_a | dec_i.op_b;
			cpu_pkg::alu_and:  result = dec_i.op_a & dec_i.op_b;
			default:           result = dec_i.op_b;
		endcase
	end

	// pc, rd and wen ride along for commit and bypass
	assign wb_o.pc     = dec_i.pc;
	assign wb_o.rd     = dec_i.rd;
	assign wb_o.wen    = dec_i.wen;
	assign wb_o.result = result;

endmodule

/* rtl/idu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module idu (
	input  logic              valid_i,
	input  cpu_pkg::fetch_t   fetch_i,

	// register file read
	output cpu_pkg::reg_idx_t rs1_o,
	output cpu_pkg::reg_idx_t rs2_o,
	input  cpu_pkg::xlen_t    rs1_data_i,
	input  cpu_pkg::xlen_t    rs2_data_i,

	// bypass sources, youngest first
	input  logic              ex_valid_i,
	input  cpu_pkg::wb_t      ex_fwd_i,
	input  logic              wb_valid_i,
	input  cpu_pkg::wb_t      wb_fwd_i,

	// towards id/ex
	output logic              valid_o,
	output cpu_pkg::dec_t     dec_o
);
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;

	logic [6:0]        opcode;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	cpu_pkg::reg_idx_t rd;
	cpu_pkg::xlen_t    imm_i;
	cpu_pkg::xlen_t    imm_u;
	cpu_pkg::xlen_t    imm;
	cpu_pkg::xlen_t    rs1_val;
	cpu_pkg::xlen_t    rs2_val;
	cpu_pkg::alu_op_e  alu_op;
	logic              supported;
	logic              use_imm;
	logic              use_pc;

	// funct3 picks the operation, alt selects sub or sra
	function automatic cpu_pkg::alu_op_e op_from_funct3(
		input logic [2:0] f3,
		input logic       alt
	);
		cpu_pkg::alu_op_e op;
		case (f3)
			3'b000: op = alt ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
			3'b001: op = cpu_pkg::alu_sll;
			3'b010: op = cpu_pkg::alu_slt;
			3'b011: op = cpu_pkg::alu_sltu;
			3'b100: op = cpu_pkg::alu_xor;
			3'b101: op = alt ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
			3'b110: op = cpu_pkg::alu_or;
			default: op = cpu_pkg::alu_and;
		endcase
		return op;
	endfunction

	// youngest in-flight writer wins, x0 is hardwired
	function automatic cpu_pkg::xlen_t pick_src(
		input cpu_pkg::reg_idx_t idx,
		input cpu_pkg::xlen_t    rf_data,
		input logic              ex_en,
		input cpu_pkg::wb_t      ex_src,
		input logic              wb_en,
		input cpu_pkg::wb_t      wb_src
	);
		cpu_pkg::xlen_t data;
		data = rf_data;
		if (idx == '0) begin
			data = '0;
		end else if (ex_en && ex_src.wen && ex_src.rd == idx) begin
			data = ex_src.result;
		end else if (wb_en && wb_src.wen && wb_src.rd == idx) begin
			data = wb_src.result;
		end
		return data;
	endfunction

	assign opcode = fetch_i.inst[6:0];
	assign funct3 = fetch_i.inst[14:12];
	assign funct7 = fetch_i.inst[31:25];
	assign rd     = fetch_i.inst[11:7];
	assign rs1_o  = fetch_i.inst[19:15];
	assign rs2_o  = fetch_i.inst[24:20];

	assign imm_i = {{(`CPU_XLEN-12){fetch_i.inst[31]}}, fetch_i.inst[31:20]};
	assign imm_u = {fetch_i.inst[31:12], 12'b0};

	always_comb begin
		supported = 1'b0;
		alu_op    = cpu_pkg::alu_add;
		use_imm   = 1'b0;
		use_pc    = 1'b0;
		imm       = imm_i;
		case (opcode)
			opc_op: begin
				// only sub and sra have the alternate funct7
				supported = (funct7 == 7'b0000000) ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
				alu_op = op_from_funct3(funct3, funct7[5]);
			end
			opc_op_imm: begin
				use_imm = 1'b1;
				alu_op  = op_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
				case (funct3)
					3'b001: supported = (funct7 == 7'b0000000);
					3'b101: supported = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
					default: supported = 1'b1;
				endcase
			end
			opc_lui: begin
				supported = 1'b1;
				use_imm   = 1'b1;
				imm       = imm_u;
				alu_op    = cpu_pkg::alu_pass_b;
			end
			opc_auipc: begin
				supported = 1'b1;
				use_imm   = 1'b1;
				use_pc    = 1'b1;
				imm       = imm_u;
			end
			default: begin
				supported = 1'b0;
			end
		endcase
	end

	assign rs1_val = pick_src(rs1_o, rs1_data_i, ex_valid_i, ex_fwd_i, wb_valid_i, wb_fwd_i);
	assign rs2_val = pick_src(rs2_o, rs2_data_i, ex_valid_i, ex_fwd_i, wb_valid_i, wb_fwd_i);

	assign valid_o      = valid_i;
	assign dec_o.pc     = fetch_i.pc;
	assign dec_o.alu_op = alu_op;
	assign dec_o.op_a   = use_pc ? fetch_i.pc : rs1_val;
	assign dec_o.op_b   = use_imm ? imm : rs2_val;
	assign dec_o.rd     = rd;
	// unknown encodings flow on as no-write
	assign dec_o.wen    = supported && (rd != '0);

endmodule

/* rtl/ifu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module ifu (
	input  logic            clock,
	input  logic            arst_n_i,

	// instruction port
	output logic            inst_req_o,
	output cpu_pkg::xlen_t  inst_addr_o,
	input  logic            inst_valid_i,
	input  cpu_pkg::xlen_t  inst_i,

	// towards if/id
	output logic            fetch_valid_o,
	output cpu_pkg::fetch_t fetch_o
);
	// address of the pending request, or of the next one to issue
	cpu_pkg::xlen_t pc_q;
	cpu_pkg::xlen_t pc_next;
	logic           pending_q;

	assign pc_next = pc_q + cpu_pkg::xlen_t'(4);

	// new request when idle or when the pending one is answered
	// held off while reset is asserted
	assign inst_req_o = arst_n_i && (!pending_q || inst_valid_i);

	// an answer frees the port for the following word right away
	assign inst_addr_o = inst_valid_i ? pc_next : pc_q;

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q          <= `CPU_RESET_PC;
			pending_q     <= 1'b0;
			fetch_valid_o <= 1'b0;
		end else begin
			pending_q     <= inst_req_o || (pending_q && !inst_valid_i);
			fetch_valid_o <= inst_valid_i;
			if (inst_valid_i) begin
				pc_q <= pc_next;
			end
		end
	end

	// pair the returned word with its address
	always_ff @(posedge clock) begin
		fetch_o.pc   <= pc_q;
		fetch_o.inst <= inst_i;
	end

endmodule

/* rtl/regfile.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module regfile (
	input  logic              clock,
	input  logic              arst_n_i,
	input  cpu_pkg::reg_idx_t raddr1_i,
	input  cpu_pkg::reg_idx_t raddr2_i,
	output cpu_pkg::xlen_t    rdata1_o,
	output cpu_pkg::xlen_t    rdata2_o,
	input  logic              wen_i,
	input  cpu_pkg::reg_idx_t waddr_i,
	input  cpu_pkg::xlen_t    wdata_i
);
	cpu_pkg::xlen_t regs [`CPU_REG_NUM];

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `CPU_REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && waddr_i != '0) begin
			// x0 keeps its reset value forever
			regs[waddr_i] <= wdata_i;
		end
	end

	// read ports are asynchronous
	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

endmodule

/* rtl/pipe_reg.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     arst_n_i,
	input  logic     valid_i,
	input  payload_t data_i,
	output logic     valid_o,
	output payload_t data_o
);
	// no back-pressure, so every edge advances the stage
	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	// bubbles carry stale payload, valid qualifies it
	always_ff @(posedge clock) begin
		data_o <= data_i;
	end

endmodule

/* rtl/cpu_pkg.sv */
`include "cpu_settings.svh"

package cpu_pkg;

	// machine word, also used for addresses
	typedef logic [`CPU_XLEN-1:0] xlen_t;

	// architectural register index
	typedef logic [`CPU_REG_AW-1:0] reg_idx_t;

	// alu operations
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		// lui result is the immediate itself
		alu_pass_b
	} alu_op_e;

	// if/id payload
	typedef struct packed {
		xlen_t pc;
		xlen_t inst;
	} fetch_t;

	// id/ex payload, operands already resolved
	typedef struct packed {
		xlen_t    pc;
		alu_op_e  alu_op;
		xlen_t    op_a;
		xlen_t    op_b;
		reg_idx_t rd;
		logic     wen;
	} dec_t;

	// ex/wb payload, also the bypass source
	typedef struct packed {
		xlen_t    pc;
		reg_idx_t rd;
		logic     wen;
		xlen_t    result;
	} wb_t;

endpackage

/* rtl/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data and address width
`define CPU_XLEN 32

// architectural register file
`define CPU_REG_NUM 32
`define CPU_REG_AW 5

// first fetch address after reset
`define CPU_RESET_PC 32'h8000_0000

`endif
